// ==== common/rmt_pkg.sv ====
package rmt_pkg;

	// stream and wishbone word
	localparam int WORD_W = 32;
	localparam int FIELD_W = 12;
	localparam int TOKEN_W = 6;

	// action table geometry
	localparam int SLOT_W = 4;
	localparam int TABLE_SLOTS = 16;

	localparam logic [TOKEN_W-1:0] TOKEN_RESET = 6'h2a;

	// wishbone word addresses
	localparam logic [1:0] REG_TOKEN = 2'd0;
	localparam logic [1:0] REG_DROPS = 2'd1;
	localparam logic [1:0] REG_CTRLS = 2'd2;

	localparam int CNT_W = 16;

	typedef struct packed {
		logic [WORD_W-1:0] data;
		logic              last;
	} beat_t;

	// kinds 0 and 3 are dropped at ingress
	typedef enum logic [1:0] {
		KIND_RSVD0 = 2'd0,
		KIND_DATA  = 2'd1,
		KIND_CTRL  = 2'd2,
		KIND_RSVD3 = 2'd3
	} kind_e;

	typedef struct packed {
		kind_e              kind;
		logic [5:0]         tag;
		logic [FIELD_W-1:0] field_a;
		logic [FIELD_W-1:0] field_b;
	} data_hdr_t;

	// target 0 selects field_a, 1 selects field_b
	typedef struct packed {
		kind_e              kind;
		logic [TOKEN_W-1:0] token;
		logic [3:0]         stage_id;
		logic [SLOT_W-1:0]  slot;
		logic               target;
		logic [2:0]         pad;
		logic [FIELD_W-1:0] value;
	} ctrl_hdr_t;

	// first word of every packet, read either way
	typedef union packed {
		data_hdr_t data;
		ctrl_hdr_t ctrl;
	} hdr_word_u;

	typedef struct packed {
		logic [5:0]         tag;
		logic [FIELD_W-1:0] field_a;
		logic [FIELD_W-1:0] field_b;
	} phv_t;

	// broadcast to every stage for one cycle
	typedef struct packed {
		logic               en;
		logic [3:0]         stage_id;
		logic [SLOT_W-1:0]  slot;
		logic               target;
		logic [FIELD_W-1:0] value;
	} tbl_wr_t;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 16
) (
	input  logic             clk,
	input  logic             aresetn,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             full,
	output logic             empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;

	assign full  = count == (AW+1)'(DEPTH);
	assign empty = count == '0;
	// fall-through, head word always visible
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// pointers wrap at DEPTH, so any depth works
			if (wr_en) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// callers must look at full and empty first
	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn)
		!(wr_en && full) && !(rd_en && empty));

endmodule

// ==== src/rmt_regs.sv ====
`timescale 1ns/10ps

module rmt_regs (
	input  logic                        clk,
	input  logic                        aresetn,
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [1:0]                  wb_adr,
	input  logic [rmt_pkg::WORD_W-1:0]  wb_dat_w,
	input  logic                        drop_pulse,
	input  logic                        ctrl_pulse,
	output logic [rmt_pkg::WORD_W-1:0]  wb_dat_r,
	output logic                        wb_ack,
	output logic [rmt_pkg::TOKEN_W-1:0] ctrl_token
);

	logic [rmt_pkg::CNT_W-1:0] drop_cnt;
	logic [rmt_pkg::CNT_W-1:0] ctrl_cnt;
	logic wb_req;

	// new cycle seen, ack goes out next clock
	assign wb_req = wb_cyc && wb_stb && !wb_ack;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wb_ack     <= 1'b0;
			ctrl_token <= rmt_pkg::TOKEN_RESET;
			drop_cnt   <= '0;
			ctrl_cnt   <= '0;
		end else begin
			wb_ack <= wb_req;
			// only the token is writable
			if (wb_req && wb_we && wb_adr == rmt_pkg::REG_TOKEN) begin
				ctrl_token <= wb_dat_w[rmt_pkg::TOKEN_W-1:0];
			end
			// counters stick at all ones
			if (drop_pulse && drop_cnt != '1) begin
				drop_cnt <= drop_cnt + 1'b1;
			end
			if (ctrl_pulse && ctrl_cnt != '1) begin
				ctrl_cnt <= ctrl_cnt + 1'b1;
			end
		end
	end

	// read data captured with the request, valid alongside ack
	always_ff @(posedge clk) begin
		if (wb_req) begin
			case (wb_adr)
				rmt_pkg::REG_TOKEN: wb_dat_r <= rmt_pkg::WORD_W'(ctrl_token);
				rmt_pkg::REG_DROPS: wb_dat_r <= rmt_pkg::WORD_W'(drop_cnt);
				rmt_pkg::REG_CTRLS: wb_dat_r <= rmt_pkg::WORD_W'(ctrl_cnt);
				default:            wb_dat_r <= '0;
			endcase
		end
	end

	// master keeps cyc and stb up through the acking clock
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (!aresetn)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

// ==== pkt_filter/pkt_filter.sv ====
`timescale 1ns/10ps

module pkt_filter (
	input  logic                        clk,
	input  logic                        aresetn,
	input  rmt_pkg::beat_t              in_beat,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  logic [rmt_pkg::TOKEN_W-1:0] ctrl_token,
	input  logic                        pkt_fifo_full,
	input  logic                        phv_ready,
	output logic                        pkt_wr_en,
	output rmt_pkg::beat_t              pkt_wr_beat,
	output rmt_pkg::phv_t               phv_out,
	output logic                        phv_valid,
	output rmt_pkg::tbl_wr_t            tbl_wr,
	output logic                        drop_pulse,
	output logic                        ctrl_pulse
);

	rmt_pkg::hdr_word_u hdr;
	// high between header and last beat
	logic in_pkt;
	// class of the packet in flight, only data is forwarded
	logic pkt_is_data;
	logic hdr_is_data;
	logic hdr_is_ctrl;
	logic token_ok;
	logic beat_acc;
	logic hdr_acc;
	logic ctrl_ok;

	assign hdr = in_beat.data;
	assign hdr_is_data = hdr.data.kind == rmt_pkg::KIND_DATA;
	assign hdr_is_ctrl = hdr.ctrl.kind == rmt_pkg::KIND_CTRL;
	assign token_ok = hdr.ctrl.token == ctrl_token;

	// header needs room in both the packet fifo and stage 0
	// later beats of control or dropped packets are just swallowed
	always_comb begin
		if (!in_pkt) begin
			in_ready = !pkt_fifo_full && phv_ready;
		end else if (pkt_is_data) begin
			in_ready = !pkt_fifo_full;
		end else begin
			in_ready = 1'b1;
		end
	end

	assign beat_acc = in_valid && in_ready;
	assign hdr_acc  = beat_acc && !in_pkt;
	assign ctrl_ok  = hdr_acc && hdr_is_ctrl && token_ok;

	// every beat of a data packet is buffered, header included
	assign pkt_wr_en   = beat_acc && (in_pkt ? pkt_is_data : hdr_is_data);
	assign pkt_wr_beat = in_beat;

	// phv offered with the header, same cycle
	assign phv_valid = in_valid && !in_pkt && hdr_is_data && !pkt_fifo_full;
	assign phv_out = '{
		tag:     hdr.data.tag,
		field_a: hdr.data.field_a,
		field_b: hdr.data.field_b
	};

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			in_pkt      <= 1'b0;
			pkt_is_data <= 1'b0;
			tbl_wr      <= '0;
			drop_pulse  <= 1'b0;
			ctrl_pulse  <= 1'b0;
		end else begin
			if (beat_acc) begin
				in_pkt <= !in_beat.last;
			end
			if (hdr_acc) begin
				pkt_is_data <= hdr_is_data;
			end
			// table write and counters trail the header by one cycle
			tbl_wr.en  <= ctrl_ok;
			ctrl_pulse <= ctrl_ok;
			// bad kind or bad token both count as drops
			drop_pulse <= hdr_acc && !hdr_is_data && !(hdr_is_ctrl && token_ok);
			if (ctrl_ok) begin
				tbl_wr.stage_id <= hdr.ctrl.stage_id;
				tbl_wr.slot     <= hdr.ctrl.slot;
				tbl_wr.target   <= hdr.ctrl.target;
				tbl_wr.value    <= hdr.ctrl.value;
			end
		end
	end

endmodule

// ==== match_action/ma_stage.sv ====
`timescale 1ns/10ps

module ma_stage #(
	parameter int STAGE_ID = 0
) (
	input  logic             clk,
	input  logic             aresetn,
	input  rmt_pkg::phv_t    phv_in,
	input  logic             phv_in_valid,
	output logic             ready,
	output rmt_pkg::phv_t    phv_out,
	output logic             phv_out_valid,
	input  logic             next_ready,
	input  rmt_pkg::tbl_wr_t tbl_wr
);

	// action table, one entry per tag low bits
	logic [rmt_pkg::TABLE_SLOTS-1:0] ent_valid;
	logic ent_target [rmt_pkg::TABLE_SLOTS];
	logic [rmt_pkg::FIELD_W-1:0] ent_value [rmt_pkg::TABLE_SLOTS];

	logic [rmt_pkg::SLOT_W-1:0] idx;
	logic wr_here;
	logic accept;
	rmt_pkg::phv_t phv_next;

	assign idx = phv_in.tag[rmt_pkg::SLOT_W-1:0];
	assign wr_here = tbl_wr.en && tbl_wr.stage_id == 4'(STAGE_ID);

	// slot free or being emptied this cycle
	assign ready  = !phv_out_valid || next_ready;
	assign accept = phv_in_valid && ready;

	// add wraps at 12 bits
	always_comb begin
		phv_next = phv_in;
		if (ent_valid[idx]) begin
			if (ent_target[idx]) begin
				phv_next.field_b = phv_in.field_b + ent_value[idx];
			end else begin
				phv_next.field_a = phv_in.field_a + ent_value[idx];
			end
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			ent_valid     <= '0;
			phv_out_valid <= 1'b0;
		end else begin
			if (wr_here) begin
				ent_valid[tbl_wr.slot] <= 1'b1;
			end
			if (accept) begin
				phv_out_valid <= 1'b1;
			end else if (next_ready) begin
				phv_out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (wr_here) begin
			ent_target[tbl_wr.slot] <= tbl_wr.target;
			ent_value[tbl_wr.slot]  <= tbl_wr.value;
		end
		if (accept) begin
			phv_out <= phv_next;
		end
	end

	// stalled upstream offer held until this stage takes it
	a_hold_on_stall: assert property (@(posedge clk) disable iff (!aresetn)
		phv_in_valid && !ready |=> phv_in_valid && $stable(phv_in));

endmodule

// ==== deparser/deparser.sv ====
`timescale 1ns/10ps

module deparser (
	input  logic           clk,
	input  logic           aresetn,
	input  rmt_pkg::beat_t pkt_beat,
	input  logic           pkt_empty,
	output logic           pkt_rd_en,
	input  rmt_pkg::phv_t  phv,
	input  logic           phv_empty,
	output logic           phv_rd_en,
	output rmt_pkg::beat_t out_beat,
	output logic           out_valid,
	input  logic           out_ready
);

	// 0 waits for a header, 1 copies payload until last
	logic in_body;
	logic can_load;
	logic start;
	logic body_mv;
	rmt_pkg::data_hdr_t new_hdr;

	// output register free or draining this cycle
	assign can_load = !out_valid || out_ready;

	// a packet starts only once its phv has come through the stages
	assign start   = !in_body && can_load && !pkt_empty && !phv_empty;
	assign body_mv = in_body && can_load && !pkt_empty;

	assign pkt_rd_en = start || body_mv;
	assign phv_rd_en = start;

	// header rebuilt from the phv, always a data kind
	assign new_hdr = '{
		kind:    rmt_pkg::KIND_DATA,
		tag:     phv.tag,
		field_a: phv.field_a,
		field_b: phv.field_b
	};

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			in_body   <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (pkt_rd_en) begin
				out_valid <= 1'b1;
				// single-beat packets never enter the body state
				in_body   <= !pkt_beat.last;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			out_beat.data <= new_hdr;
			// last flag from the buffered header beat
			out_beat.last <= pkt_beat.last;
		end else if (body_mv) begin
			out_beat <= pkt_beat;
		end
	end

endmodule

// ==== src/rmt_top.sv ====
`timescale 1ns/10ps

module rmt_top #(
	parameter int N_STAGES = 2,
	parameter int PKT_FIFO_DEPTH = 16,
	parameter int PHV_FIFO_DEPTH = 4
) (
	input  logic                       clk,
	input  logic                       aresetn,
	input  rmt_pkg::beat_t             in_beat,
	input  logic                       in_valid,
	output logic                       in_ready,
	output rmt_pkg::beat_t             out_beat,
	output logic                       out_valid,
	input  logic                       out_ready,
	input  logic                       wb_cyc,
	input  logic                       wb_stb,
	input  logic                       wb_we,
	input  logic [1:0]                 wb_adr,
	input  logic [rmt_pkg::WORD_W-1:0] wb_dat_w,
	output logic [rmt_pkg::WORD_W-1:0] wb_dat_r,
	output logic                       wb_ack
);

	logic [rmt_pkg::TOKEN_W-1:0] ctrl_token;
	logic drop_pulse;
	logic ctrl_pulse;
	rmt_pkg::tbl_wr_t tbl_wr;

	// phv links, index 0 is the filter, N_STAGES feeds the phv fifo
	rmt_pkg::phv_t phv_chain [N_STAGES+1];
	logic [N_STAGES:0] phv_valid_chain;
	logic [N_STAGES:0] phv_ready_chain;

	logic pkt_wr_en;
	rmt_pkg::beat_t pkt_wr_beat;
	logic pkt_full;
	logic pkt_empty;
	logic pkt_rd_en;
	rmt_pkg::beat_t pkt_rd_beat;

	logic phv_wr_en;
	logic phv_full;
	logic phv_empty;
	logic phv_rd_en;
	rmt_pkg::phv_t phv_rd;

	rmt_regs regs0 (
		.clk        (clk),
		.aresetn    (aresetn),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.drop_pulse (drop_pulse),
		.ctrl_pulse (ctrl_pulse),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.ctrl_token (ctrl_token)
	);

	pkt_filter filter0 (
		.clk           (clk),
		.aresetn       (aresetn),
		.in_beat       (in_beat),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.ctrl_token    (ctrl_token),
		.pkt_fifo_full (pkt_full),
		.phv_ready     (phv_ready_chain[0]),
		.pkt_wr_en     (pkt_wr_en),
		.pkt_wr_beat   (pkt_wr_beat),
		.phv_out       (phv_chain[0]),
		.phv_valid     (phv_valid_chain[0]),
		.tbl_wr        (tbl_wr),
		.drop_pulse    (drop_pulse),
		.ctrl_pulse    (ctrl_pulse)
	);

	for (genvar i = 0; i < N_STAGES; i++) begin : g_stage
		ma_stage #(
			.STAGE_ID (i)
		) stage0 (
			.clk           (clk),
			.aresetn       (aresetn),
			.phv_in        (phv_chain[i]),
			.phv_in_valid  (phv_valid_chain[i]),
			.ready         (phv_ready_chain[i]),
			.phv_out       (phv_chain[i+1]),
			.phv_out_valid (phv_valid_chain[i+1]),
			.next_ready    (phv_ready_chain[i+1]),
			.tbl_wr        (tbl_wr)
		);
	end

	// last stage drains into the phv fifo while it has room
	assign phv_ready_chain[N_STAGES] = !phv_full;
	assign phv_wr_en = phv_valid_chain[N_STAGES] && !phv_full;

	sync_fifo #(
		.WIDTH ($bits(rmt_pkg::beat_t)),
		.DEPTH (PKT_FIFO_DEPTH)
	) pkt_fifo0 (
		.clk     (clk),
		.aresetn (aresetn),
		.wr_en   (pkt_wr_en),
		.wr_data (pkt_wr_beat),
		.rd_en   (pkt_rd_en),
		.rd_data (pkt_rd_beat),
		.full    (pkt_full),
		.empty   (pkt_empty)
	);

	sync_fifo #(
		.WIDTH ($bits(rmt_pkg::phv_t)),
		.DEPTH (PHV_FIFO_DEPTH)
	) phv_fifo0 (
		.clk     (clk),
		.aresetn (aresetn),
		.wr_en   (phv_wr_en),
		.wr_data (phv_chain[N_STAGES]),
		.rd_en   (phv_rd_en),
		.rd_data (phv_rd),
		.full    (phv_full),
		.empty   (phv_empty)
	);

	deparser deparser0 (
		.clk       (clk),
		.aresetn   (aresetn),
		.pkt_beat  (pkt_rd_beat),
		.pkt_empty (pkt_empty),
		.pkt_rd_en (pkt_rd_en),
		.phv       (phv_rd),
		.phv_empty (phv_empty),
		.phv_rd_en (phv_rd_en),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

// ==== verification/rmt_checker.sv ====
`timescale 1ns/10ps

module rmt_checker #(
	parameter int N_STAGES = 2
) (
	input  logic           clk,
	input  logic           aresetn,
	input  rmt_pkg::beat_t in_beat,
	input  logic           in_valid,
	input  logic           in_ready,
	input  rmt_pkg::beat_t out_beat,
	input  logic           out_valid,
	input  logic           out_ready,
	input  logic           wb_cyc,
	input  logic           wb_stb,
	input  logic           wb_we,
	input  logic [1:0]     wb_adr,
	input  logic [31:0]    wb_dat_w,
	input  logic [31:0]    wb_dat_r,
	input  logic           wb_ack,
	output int             stream_errs,
	output int             reg_errs,
	output int             pending
);

	// action tables as the accepted control packets leave them
	logic ent_valid [16][16];
	logic ent_target [16][16];
	logic [11:0] ent_value [16][16];
	logic [5:0] token;
	int drops;
	int ctrls;
	// packet tracking on the input side
	logic in_pkt;
	logic fwd_pkt;
	logic [1:0] kind;
	logic [3:0] sid;
	logic [3:0] slot;
	logic [31:0] exp_rd;
	rmt_pkg::beat_t exp_beat;
	rmt_pkg::beat_t new_beat;
	// beats still owed by the DUT, oldest first
	rmt_pkg::beat_t exp_q [$];
	int beats_out;

	initial begin
		for (int s = 0; s < 16; s++) begin
			for (int e = 0; e < 16; e++) begin
				ent_valid[s][e] = 1'b0;
			end
		end
		token = 6'h2a;
		drops = 0;
		ctrls = 0;
		in_pkt = 1'b0;
		fwd_pkt = 1'b0;
		stream_errs = 0;
		reg_errs = 0;
		pending = 0;
		beats_out = 0;
	end

	// header fields: kind 31:30, tag 29:24, field_a 23:12, field_b 11:0
	function automatic logic [31:0] rewrite_header(input logic [31:0] word);
		logic [5:0] tag;
		logic [11:0] fa;
		logic [11:0] fb;
		logic [3:0] idx;
		tag = word[29:24];
		fa = word[23:12];
		fb = word[11:0];
		idx = tag[3:0];
		// every stage adds its entry, 12-bit wrap
		for (int s = 0; s < N_STAGES; s++) begin
			if (ent_valid[s][idx]) begin
				if (ent_target[s][idx]) begin
					fb = fb + ent_value[s][idx];
				end else begin
					fa = fa + ent_value[s][idx];
				end
			end
		end
		return {2'b01, tag, fa, fb};
	endfunction

	// counters stop at all ones
	function automatic logic [31:0] sat16(input int n);
		return (n > 65535) ? 32'd65535 : 32'(n);
	endfunction

	always @(posedge clk) begin
		if (aresetn) begin
			// output side first, a beat never passes straight through
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					$display("Unexpected output at %0t: out_valid high with nothing pending",
						$time);
					stream_errs++;
				end else if (out_ready) begin
					exp_beat = exp_q.pop_front();
					if (out_beat !== exp_beat) begin
						$display("ERROR at %0t: output beat %0d is %h last %b, expected %h last %b",
							$time, beats_out, out_beat.data, out_beat.last,
							exp_beat.data, exp_beat.last);
						stream_errs++;
					end
					beats_out++;
				end
			end
			// input side, one accepted beat per clock at most
			if (in_valid && in_ready) begin
				if (!in_pkt) begin
					kind = in_beat.data[31:30];
					fwd_pkt = kind == 2'd1;
					if (fwd_pkt) begin
						new_beat.data = rewrite_header(in_beat.data);
						new_beat.last = in_beat.last;
						exp_q.push_back(new_beat);
					end else if (kind == 2'd2 && in_beat.data[29:24] == token) begin
						// control layout: stage 23:20, slot 19:16, target 15, value 11:0
						ctrls++;
						sid = in_beat.data[23:20];
						slot = in_beat.data[19:16];
						if (int'(sid) < N_STAGES) begin
							ent_valid[sid][slot] = 1'b1;
							ent_target[sid][slot] = in_beat.data[15];
							ent_value[sid][slot] = in_beat.data[11:0];
						end
					end else begin
						drops++;
					end
				end else if (fwd_pkt) begin
					exp_q.push_back(in_beat);
				end
				in_pkt = !in_beat.last;
			end
			// wishbone, looked at on the acking clock
			if (wb_ack && !(wb_cyc && wb_stb)) begin
				$display("Bus error at %0t: wb_ack high outside a bus cycle", $time);
				reg_errs++;
			end else if (wb_ack) begin
				if (wb_we) begin
					if (wb_adr == 2'd0) begin
						token = wb_dat_w[5:0];
					end
				end else begin
					case (wb_adr)
						2'd0:    exp_rd = {26'd0, token};
						2'd1:    exp_rd = sat16(drops);
						2'd2:    exp_rd = sat16(ctrls);
						default: exp_rd = 32'd0;
					endcase
					if (wb_dat_r !== exp_rd) begin
						$display("ERROR at %0t: register %0d read %h, expected %h",
							$time, wb_adr, wb_dat_r, exp_rd);
						reg_errs++;
					end
				end
			end
			pending = exp_q.size();
		end
	end

endmodule

// ==== verification/tb_rmt_top.sv ====
`timescale 1ns/10ps

module tb_rmt_top;

	localparam int N_STAGES = 2;
	localparam int N_PKTS = 200;

	logic clk;
	logic aresetn;
	rmt_pkg::beat_t in_beat;
	logic in_valid;
	logic in_ready;
	rmt_pkg::beat_t out_beat;
	logic out_valid;
	logic out_ready;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;
	int stream_errs;
	int reg_errs;
	int pending;
	int seed;
	int beats_sent;
	int cycles;

	rmt_top #(
		.N_STAGES (N_STAGES)
	) dut0 (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_beat   (in_beat),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_beat  (out_beat),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack)
	);

	rmt_checker #(
		.N_STAGES (N_STAGES)
	) chk0 (
		.clk         (clk),
		.aresetn     (aresetn),
		.in_beat     (in_beat),
		.in_valid    (in_valid),
		.in_ready    (in_ready),
		.out_beat    (out_beat),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.stream_errs (stream_errs),
		.reg_errs    (reg_errs),
		.pending     (pending)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// random back-pressure, ready about three cycles in four
	always @(negedge clk) begin
		if (aresetn) begin
			out_ready = ($random(seed) & 3) != 0;
		end
	end

	// limit grows with the traffic sent so far
	always @(posedge clk) begin
		cycles++;
		if (cycles > 100 * beats_sent + 2000) begin
			$display("Timeout: the run did not finish within %0d cycles", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		return ($random(seed) & 32'h7fffffff) % n;
	endfunction

	// control header, same bit order as ctrl_hdr_t
	function automatic logic [31:0] ctrl_word(input logic [5:0] tok, input logic [3:0] stage,
		input logic [3:0] slot, input logic target, input logic [11:0] value);
		return {2'd2, tok, stage, slot, target, 3'b000, value};
	endfunction

	// all tasks start and end on a falling edge
	task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = dat;
		@(negedge clk);
		while (!wb_ack) begin
			@(negedge clk);
		end
		// hold through the acking edge
		@(negedge clk);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic bus_write(input logic [1:0] adr, input logic [31:0] dat);
		bus_cycle(1'b1, adr, dat);
	endtask

	task automatic bus_read(input logic [1:0] adr);
		bus_cycle(1'b0, adr, 32'd0);
	endtask

	// in_ready depends only on DUT state, so it is settled here
	task automatic put_beat(input logic [31:0] data, input logic last);
		logic taken;
		while (($random(seed) & 7) == 0) begin
			@(negedge clk);
		end
		in_beat.data = data;
		in_beat.last = last;
		in_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			taken = in_ready;
			@(negedge clk);
		end
		in_valid = 1'b0;
		beats_sent++;
	endtask

	task automatic send_packet(input logic [31:0] hdr, input int n_beats);
		logic [31:0] word;
		for (int i = 0; i < n_beats; i++) begin
			word = (i == 0) ? hdr : $random(seed);
			put_beat(word, i == n_beats - 1);
		end
	endtask

	task automatic send_data(input int n_pkts, input logic with_drops);
		logic [31:0] hdr;
		for (int p = 0; p < n_pkts; p++) begin
			hdr = $random(seed);
			hdr[31:30] = 2'd1;
			send_packet(hdr, 1 + rand_below(6));
			// kind 0 or 3 now and then
			if (with_drops && rand_below(4) == 0) begin
				hdr = $random(seed);
				hdr[31:30] = (rand_below(2) == 0) ? 2'd0 : 2'd3;
				send_packet(hdr, 1 + rand_below(6));
			end
		end
	endtask

	// empty pipeline, then a few clocks for counter pulses and table writes
	task automatic wait_drain();
		while (pending != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
	endtask

	task automatic configure(input logic [5:0] tok, input int n_writes);
		wait_drain();
		for (int i = 0; i < n_writes; i++) begin
			send_packet(ctrl_word(tok, 4'(rand_below(N_STAGES)), 4'(rand_below(16)),
				1'(rand_below(2)), 12'(rand_below(4096))), 1 + rand_below(3));
		end
		// both of these must leave the tables alone
		send_packet(ctrl_word(tok ^ 6'h01, 4'd0, 4'd0, 1'b0, 12'h7ff), 2);
		send_packet(ctrl_word(tok, 4'(N_STAGES), 4'd1, 1'b0, 12'h123), 1);
		wait_drain();
	endtask

	initial begin
		seed = 53135;
		clk = 1'b0;
		aresetn = 1'b0;
		in_beat = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 32'd0;
		beats_sent = 0;
		cycles = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		aresetn = 1'b1;
		// registers: reset token, 6-bit write, read-only counters, unmapped word
		bus_read(2'd0);
		bus_write(2'd0, 32'hffff_ff55);
		bus_read(2'd0);
		bus_write(2'd1, 32'h0000_1234);
		bus_write(2'd2, 32'h0000_5678);
		bus_write(2'd3, 32'hdead_beef);
		bus_read(2'd1);
		bus_read(2'd2);
		bus_read(2'd3);
		// tables still empty
		send_data(20, 1'b0);
		configure(6'h15, 12);
		send_data(N_PKTS, 1'b1);
		// new token, old one becomes a wrong token
		wait_drain();
		bus_write(2'd0, 32'h0000_003c);
		send_packet(ctrl_word(6'h15, 4'd0, 4'd2, 1'b1, 12'h0ff), 1);
		configure(6'h3c, 12);
		send_data(N_PKTS, 1'b1);
		wait_drain();
		bus_read(2'd1);
		bus_read(2'd2);
		bus_read(2'd0);
		$display("Errors: stream %0d, register %0d, beats never delivered %0d",
			stream_errs, reg_errs, pending);
		if (stream_errs == 0 && reg_errs == 0 && pending == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== sources.f ====
common/rmt_pkg.sv
src/sync_fifo.sv
src/rmt_regs.sv
pkt_filter/pkt_filter.sv
match_action/ma_stage.sv
deparser/deparser.sv
src/rmt_top.sv
verification/rmt_checker.sv
verification/tb_rmt_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rmt_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
